/* logic/isaPkg.sv */
`default_nettype none

package isaPkg;

    ////////////////////////////////////////////////////////////
    // Field encodings

    localparam logic [1:0] OP_DP  = 2'b00;
    localparam logic [1:0] OP_MEM = 2'b01;
    localparam logic [1:0] OP_BR  = 2'b10;

    localparam logic [3:0] MUL_PATTERN = 4'b1001; // Bits 7:4 of MUL
    localparam logic [3:0] DIV_PATTERN = 4'b1111; // Bits 7:4 of DIV
    localparam logic [3:0] PC_REG      = 4'd15;

    typedef enum logic [3:0] {
        EQ = 4'h0, NE = 4'h1, CS = 4'h2, CC = 4'h3,
        MI = 4'h4, PL = 4'h5, VS = 4'h6, VC = 4'h7,
        HI = 4'h8, LS = 4'h9, GE = 4'ha, LT = 4'hb,
        GT = 4'hc, LE = 4'hd, AL = 4'he
    } condT;

    typedef enum logic [3:0] {
        AND = 4'h0, EOR = 4'h1, SUB = 4'h2, RSB = 4'h3,
        ADD = 4'h4, ADC = 4'h5, SBC = 4'h6, RSC = 4'h7,
        TST = 4'h8, TEQ = 4'h9, CMP = 4'ha, CMN = 4'hb,
        ORR = 4'hc, MOV = 4'hd, BIC = 4'he, MVN = 4'hf
    } dpOpT;

    ////////////////////////////////////////////////////////////
    // Instruction formats

    typedef struct packed {
        condT        cond;
        logic [1:0]  op;
        logic        immFlag;
        dpOpT        opcode;
        logic        setFlags;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] operand2;
    } dpFmtT;

    typedef struct packed {
        condT        cond;
        logic [1:0]  op;
        logic        iBar;      // Low selects immediate offset
        logic        pre;
        logic        up;
        logic        byteFlag;
        logic        writeBack;
        logic        load;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] offset;
    } memFmtT;

    typedef struct packed {
        condT        cond;
        logic [1:0]  op;
        logic [1:0]  linkFunct;
        logic [23:0] imm24;
    } brFmtT;

    // Same 32 bits seen through each format
    typedef union packed {
        dpFmtT       dp;
        memFmtT      mem;
        brFmtT       br;
        logic [31:0] raw;
    } instrT;

endpackage

`default_nettype wire

/* logic/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    // ALU shares the DP opcode encoding and uses ADD for addresses
    typedef isaPkg::dpOpT aluOpT;

    ////////////////////////////////////////////////////////////
    // Control bundles

    typedef struct packed {
        logic       regW;
        logic       memW;
        logic       memToReg;
        logic       branch;
        logic       noWrite;   // Compare ops discard the result
        logic [3:0] flagW;     // Flag enables in n z c v order
        aluOpT      aluControl;
        logic [1:0] aluSrc;
        logic [1:0] immSrc;
        logic [2:0] regSrc;
        logic       mulDiv;
        logic       mCycleOp;  // 0 multiply, 1 divide
        logic       pcs;
    } decodeT;

    typedef struct packed {
        logic       pcSrc;
        logic       regWrite;
        logic       memWrite;
        logic       memToReg;
        logic [1:0] aluSrc;
        logic [1:0] immSrc;
        logic [2:0] regSrc;
        logic       mulDiv;
        logic       mCycleOp;
    } ctrlOutT;

endpackage

`default_nettype wire

/* logic/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  isaPkg::instrT   instr,
    output ctrlPkg::decodeT dec
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic       regW;
    logic       memW;
    logic       memToReg;
    logic       branch;
    logic       noWrite;
    logic [3:0] flagW;
    aluOpT      aluControl;
    logic [1:0] aluSrc;
    logic [1:0] immSrc;
    logic [2:0] regSrc;
    logic       mulDiv;
    logic       mCycleOp;
    logic       pcs;

    logic       isMul;
    logic       isDiv;
    logic       isLogical;
    logic       isCompare;

    // MUL sits in the register DP space with opcode AND
    assign isMul = (instr.dp.op == OP_DP) && !instr.dp.immFlag &&
                   (instr.dp.opcode == AND) &&
                   (instr.dp.operand2[7:4] == MUL_PATTERN);

    // DIV reuses an LDR encoding with every funct bit set
    assign isDiv = (instr.mem.op == OP_MEM) && (instr.raw[25:20] == 6'b111111) &&
                   (instr.mem.offset[7:4] == DIV_PATTERN);

    assign isLogical = instr.dp.opcode inside {AND, EOR, TST, TEQ, ORR, MOV, BIC, MVN};
    assign isCompare = instr.dp.opcode inside {TST, TEQ, CMP, CMN};

    ////////////////////////////////////////////////////////////
    // Main decoder

    always_comb begin
        regW     = 1'b0;
        memW     = 1'b0;
        memToReg = 1'b0;
        branch   = 1'b0;
        aluSrc   = 2'b00;
        immSrc   = 2'b00;
        regSrc   = 3'b000;
        mulDiv   = 1'b0;
        mCycleOp = 1'b0;

        case (instr.dp.op)
            OP_DP: begin
                if (isMul) begin
                    aluSrc = 2'b10;
                    regSrc = 3'b100;
                    mulDiv = 1'b1;
                end else begin
                    regW   = 1'b1;
                    aluSrc = {1'b0, instr.dp.immFlag};
                end
            end

            OP_MEM: begin
                immSrc = 2'b01;
                if (isDiv) begin
                    aluSrc   = 2'b10;
                    regSrc   = 3'b100;
                    mulDiv   = 1'b1;
                    mCycleOp = 1'b1;
                end else if (instr.mem.load) begin
                    regW     = 1'b1;
                    memToReg = 1'b1;
                    aluSrc   = {1'b0, ~instr.mem.iBar};
                end else begin
                    memW   = 1'b1;
                    aluSrc = {1'b0, ~instr.mem.iBar};
                    regSrc = 3'b010;   // Store data read from Rd
                end
            end

            OP_BR: begin
                branch = 1'b1;
                aluSrc = 2'b01;
                immSrc = 2'b10;
                regSrc = 3'b001;   // PC as first operand
            end

            default: begin
                branch = 1'b0;     // Op 11 is unused and has no side effects
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // ALU decoder

    always_comb begin
        aluControl = ADD;
        flagW      = 4'b0000;
        noWrite    = 1'b0;

        if (!mulDiv) begin
            case (instr.dp.op)
                OP_DP: begin
                    aluControl = instr.dp.opcode;
                    // Compare with S clear ends up with no writes at all
                    noWrite    = isCompare;
                    if (instr.dp.setFlags) begin
                        flagW = isLogical ? 4'b1110 : 4'b1111;
                    end
                end

                OP_MEM: begin
                    aluControl = instr.mem.up ? ADD : SUB;
                end

                default: begin
                    aluControl = ADD;  // Branch target
                end
            endcase
        end
    end

    assign pcs = (regW && !noWrite && (instr.dp.rd == PC_REG)) || branch;

    assign dec = '{
        regW:       regW,
        memW:       memW,
        memToReg:   memToReg,
        branch:     branch,
        noWrite:    noWrite,
        flagW:      flagW,
        aluControl: aluControl,
        aluSrc:     aluSrc,
        immSrc:     immSrc,
        regSrc:     regSrc,
        mulDiv:     mulDiv,
        mCycleOp:   mCycleOp,
        pcs:        pcs
    };

endmodule

`default_nettype wire

/* logic/condLogic.sv */
`timescale 1ns/1ps
`default_nettype none

module condLogic (
    input  logic             clk,
    input  logic             arstN,
    input  isaPkg::condT     cond,
    input  ctrlPkg::decodeT  dec,
    input  ctrlPkg::flagsT   aluFlags,
    output ctrlPkg::ctrlOutT ctrlOut,
    output ctrlPkg::flagsT   flags,
    output logic             carryIn
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic  condEx;
    logic  writeEn;
    flagsT flagEn;

    ////////////////////////////////////////////////////////////
    // Condition check on stored flags

    always_comb begin
        case (cond)
            EQ:      condEx = flags.z;
            NE:      condEx = !flags.z;
            CS:      condEx = flags.c;
            CC:      condEx = !flags.c;
            MI:      condEx = flags.n;
            PL:      condEx = !flags.n;
            VS:      condEx = flags.v;
            VC:      condEx = !flags.v;
            HI:      condEx = flags.c && !flags.z;
            LS:      condEx = !flags.c || flags.z;
            GE:      condEx = (flags.n == flags.v);
            LT:      condEx = (flags.n != flags.v);
            GT:      condEx = !flags.z && (flags.n == flags.v);
            LE:      condEx = flags.z || (flags.n != flags.v);
            default: condEx = 1'b1;   // AL
        endcase
    end

    assign writeEn = condEx && arstN;   // Writes held off during reset
    assign flagEn  = flagsT'(dec.flagW & {4{condEx}});
    assign carryIn = flags.c;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
        end else begin
            if (flagEn.n) flags.n <= aluFlags.n;
            if (flagEn.z) flags.z <= aluFlags.z;
            if (flagEn.c) flags.c <= aluFlags.c;
            if (flagEn.v) flags.v <= aluFlags.v;   // Logical ops keep V
        end
    end

    always_comb begin
        ctrlOut.pcSrc    = dec.pcs && writeEn;
        ctrlOut.regWrite = dec.regW && !dec.noWrite && writeEn;
        ctrlOut.memWrite = dec.memW && writeEn;
        ctrlOut.memToReg = dec.memToReg;
        ctrlOut.aluSrc   = dec.aluSrc;
        ctrlOut.immSrc   = dec.immSrc;
        ctrlOut.regSrc   = dec.regSrc;
        ctrlOut.mulDiv   = dec.mulDiv && writeEn;
        ctrlOut.mCycleOp = dec.mCycleOp;
    end

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [31:0]    srcA,
    input  logic [31:0]    srcB,
    input  ctrlPkg::aluOpT aluControl,
    input  logic           carryIn,
    output logic [31:0]    aluResult,
    output ctrlPkg::flagsT aluFlags
);
    import isaPkg::*;

    logic [31:0] addA;
    logic [31:0] addB;
    logic        addCin;
    logic [32:0] sum;
    logic        isArith;
    logic        overflow;

    ////////////////////////////////////////////////////////////
    // Operand steering for the shared adder

    always_comb begin
        addA   = srcA;
        addB   = srcB;
        addCin = 1'b0;
        case (aluControl)
            SUB, CMP: begin
                addB   = ~srcB;
                addCin = 1'b1;
            end
            RSB: begin
                addA   = srcB;
                addB   = ~srcA;
                addCin = 1'b1;
            end
            ADC: addCin = carryIn;
            SBC: begin
                addB   = ~srcB;
                addCin = carryIn;   // Borrow is inverted carry
            end
            RSC: begin
                addA   = srcB;
                addB   = ~srcA;
                addCin = carryIn;
            end
            default: addCin = 1'b0; // ADD, CMN
        endcase
    end

    assign sum      = {1'b0, addA} + {1'b0, addB} + {32'd0, addCin};
    assign overflow = (addA[31] == addB[31]) && (sum[31] != addA[31]);
    assign isArith  = aluControl inside {SUB, RSB, ADD, ADC, SBC, RSC, CMP, CMN};

    always_comb begin
        case (aluControl)
            AND, TST: aluResult = srcA & srcB;
            EOR, TEQ: aluResult = srcA ^ srcB;
            ORR:      aluResult = srcA | srcB;
            MOV:      aluResult = srcB;
            BIC:      aluResult = srcA & ~srcB;
            MVN:      aluResult = ~srcB;
            default:  aluResult = sum[31:0];
        endcase
    end

    // No shifter, so logical ops carry out zero
    assign aluFlags.n = aluResult[31];
    assign aluFlags.z = (aluResult == 32'd0);
    assign aluFlags.c = isArith && sum[32];
    assign aluFlags.v = isArith && overflow;

endmodule

`default_nettype wire

/* logic/controlPath.sv */
`timescale 1ns/1ps
`default_nettype none

module controlPath (
    input  logic             clk,
    input  logic             arstN,
    input  isaPkg::instrT    instr,
    input  logic [31:0]      srcA,
    input  logic [31:0]      srcB,
    output logic [31:0]      aluResult,
    output ctrlPkg::ctrlOutT ctrlOut,
    output ctrlPkg::flagsT   flags
);
    import ctrlPkg::*;

    decodeT dec;
    flagsT  aluFlags;
    logic   carryIn;

    instrDecoder decoder_i (
        .instr (instr),
        .dec   (dec)
    );

    condLogic condLogic_i (
        .clk      (clk),
        .arstN    (arstN),
        .cond     (instr.dp.cond),   // Same bits in every format
        .dec      (dec),
        .aluFlags (aluFlags),
        .ctrlOut  (ctrlOut),
        .flags    (flags),
        .carryIn  (carryIn)
    );

    alu alu_i (
        .srcA       (srcA),
        .srcB       (srcB),
        .aluControl (dec.aluControl),
        .carryIn    (carryIn),
        .aluResult  (aluResult),
        .aluFlags   (aluFlags)
    );

endmodule

`default_nettype wire

/* test/controlPath_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module controlPath_asserts (
    input logic             clk,
    input logic             arstN,
    input isaPkg::instrT    instr,
    input ctrlPkg::decodeT  dec,
    input logic             condEx,
    input ctrlPkg::ctrlOutT ctrlOut,
    input ctrlPkg::flagsT   flags
);
    import isaPkg::*;

    int assertFails = 0;

    // Register and memory writes are exclusive
    assert property (@(posedge clk) disable iff (!arstN)
        !(ctrlOut.regWrite && ctrlOut.memWrite))
        else begin
            assertFails = assertFails + 1;
            $error("regWrite and memWrite high together");
        end

    assert property (@(posedge clk) disable iff (!arstN)
        !condEx |=> $stable(flags))
        else begin
            assertFails = assertFails + 1;
            $error("flags changed after a failed condition");
        end

    // PC only changes through a branch or a write to R15
    assert property (@(posedge clk) disable iff (!arstN)
        ctrlOut.pcSrc |-> (dec.branch || (dec.regW && instr.dp.rd == PC_REG)))
        else begin
            assertFails = assertFails + 1;
            $error("pcSrc without branch or PC write");
        end

endmodule

bind controlPath controlPath_asserts checks_i (
    .clk     (clk),
    .arstN   (arstN),
    .instr   (instr),
    .dec     (dec),
    .condEx  (condLogic_i.condEx),
    .ctrlOut (ctrlOut),
    .flags   (flags)
);

`default_nettype wire

/* test/controlPathTb.sv */
`timescale 1ns/1ps
`default_nettype none

module controlPathTb;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int MAX_VECS = 64;
    localparam int WORDS    = 6;   // instr srcA srcB aluResult ctrlOut flags

    logic        clk;
    logic        arstN;
    instrT       instr;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] aluResult;
    ctrlOutT     ctrlOut;
    flagsT       flags;

    logic [31:0] vecMem [0:MAX_VECS*WORDS];
    int          numVecs;
    int          cycleLimit;
    int          cycles;

    controlPath controlPath_i (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .srcA      (srcA),
        .srcB      (srcB),
        .aluResult (aluResult),
        .ctrlOut   (ctrlOut),
        .flags     (flags)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Run time guard

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles before all vectors were applied", cycles);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic compareWord(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and checks

    initial begin
        int base;

        clk        = 1'b0;
        arstN      = 1'b0;
        instr      = '0;
        srcA       = '0;
        srcB       = '0;
        cycles     = 0;
        cycleLimit = 0;

        $readmemh("test/controlPathTests.mem", vecMem);
        numVecs = vecMem[0];   // First word of the file
        if (numVecs < 1 || numVecs > MAX_VECS) begin
            $display("Vector file has no usable vector count");
            $display("SIMULATION FAILED");
            $fatal(1, "bad vector file");
        end
        cycleLimit = numVecs * 2 + 20;

        // First vector is an AL write, still held off while in reset
        repeat (3) @(posedge clk);
        @(negedge clk);
        instr = vecMem[1];
        #4;
        compareWord("ctrlOut", {28'd0, ctrlOut.pcSrc, ctrlOut.regWrite, ctrlOut.memWrite,
                                ctrlOut.mulDiv}, 32'd0);
        @(negedge clk);
        arstN = 1'b1;

        for (int v = 0; v < numVecs; v++) begin
            base  = 1 + v * WORDS;
            instr = vecMem[base];
            srcA  = vecMem[base + 1];
            srcB  = vecMem[base + 2];
            #4;   // Just before the rising edge
            compareWord("aluResult", aluResult, vecMem[base + 3]);
            compareWord("ctrlOut", {19'd0, ctrlOut}, vecMem[base + 4]);
            @(posedge clk);
            #1;
            compareWord("flags", {28'd0, flags}, vecMem[base + 5]);
            @(negedge clk);
        end

        @(posedge clk);
        #1;   // One more edge for the last flag implication

        if (controlPath_i.checks_i.assertFails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/controlPathTests.mem */
// First word is the vector count, then one vector per line:
// instr srcA srcB aluResult ctrlOut flags(nzcv after the edge)
15
E0812003 00000005 00000007 0000000C 00000800 0
E2512005 00000005 00000005 00000000 00000880 6
11A03004 00000000 00001234 00001234 00000000 6
15012004 00000100 00000004 000000FC 000000A8 6
03F040FF 00000000 000000FF FFFFFF00 00000880 8
00915006 7FFFFFFF 00000001 80000000 00000000 8
E0915006 7FFFFFFF 00000001 80000000 00000800 9
E0312003 000000F0 0000000F 000000FF 00000800 1
E3510003 00000005 00000003 00000002 00000080 2
E0A12003 0000000A 00000014 0000001F 00000800 2
E0D12003 00000003 00000005 FFFFFFFE 00000800 8
E0E12003 00000002 0000000A 00000007 00000800 8
E1C12003 000000FF 0000000F 000000F0 00000800 8
E1212003 00000005 00000005 00000000 00000000 8
E5912004 00000100 00000004 00000104 00000AA0 8
E5012004 00000100 00000004 000000FC 000004A8 8
E1A0F004 00000000 00000040 00000040 00001800 8
E8000010 00001000 00000040 00001040 000010C4 8
08000010 00001000 00000040 00001040 000000C4 8
E0020091 00000003 00000004 00000007 00000112 8
E7F200F1 00000003 00000004 00000007 00000133 8

/* flist.f */
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/condLogic.sv
logic/alu.sv
logic/controlPath.sv
test/controlPath_asserts.sv
test/controlPathTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = controlPathTb
FLIST    = flist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = SIMULATION FAILED
PASS_MSG = SIMULATION PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
